// File: common/cpuPkg.sv
`default_nettype none

package cpuPkg;

    typedef logic [31:0] word_t;   // Bus, register and memory word.
    typedef logic [3:0]  regIdx_t;
    typedef logic [4:0]  opcode_t;

    localparam opcode_t opLd   = 5'b00000;
    localparam opcode_t opLdi  = 5'b00001;
    localparam opcode_t opSt   = 5'b00010;
    localparam opcode_t opAdd  = 5'b00011;
    localparam opcode_t opSub  = 5'b00100;
    localparam opcode_t opAnd  = 5'b00101;
    localparam opcode_t opOr   = 5'b00110;
    localparam opcode_t opShr  = 5'b00111;
    localparam opcode_t opShl  = 5'b01000;
    localparam opcode_t opAddi = 5'b01001;
    localparam opcode_t opAndi = 5'b01010;
    localparam opcode_t opBrzr = 5'b01011;
    localparam opcode_t opBrnz = 5'b01100;
    localparam opcode_t opIn   = 5'b01101;
    localparam opcode_t opOut  = 5'b01110;
    localparam opcode_t opHalt = 5'b11011;

    typedef enum logic [3:0] {resetState, T0, T1, T2, T3, T4, T5, T6, T7} tState_t;

    // One bit per bus driver. Bit 0 is PC and bit 5 is the sign-extended constant.
    typedef logic [5:0] busSrc_t;

    localparam busSrc_t srcPc     = 6'b000001;
    localparam busSrc_t srcZlo    = 6'b000010;
    localparam busSrc_t srcMdr    = 6'b000100;
    localparam busSrc_t srcReg    = 6'b001000;
    localparam busSrc_t srcInport = 6'b010000;
    localparam busSrc_t srcC      = 6'b100000;

    typedef struct packed {
        busSrc_t busSrc;
        logic    marIn, mdrIn, pcIn, irIn, yIn, zIn, rIn, conIn, outportIn;
        logic    gra, grb, grc, baOut;
        logic    incPc;
        opcode_t aluOp;
        logic    memRead, memWrite;
    } controlWord_t;

endpackage

`default_nettype wire

// File: datapath/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  cpuPkg::opcode_t op,
    input  cpuPkg::word_t   a,
    input  cpuPkg::word_t   b,
    input  wire             incPc,
    output cpuPkg::word_t   result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];  // Shift counts wrap at 32.

    always_comb begin
        if (incPc) begin
            result = b + 32'd1;
        end else begin
            case (op)
                cpuPkg::opSub:  result = a - b;
                cpuPkg::opAnd,
                cpuPkg::opAndi: result = a & b;
                cpuPkg::opOr:   result = a | b;
                cpuPkg::opShr:  result = a >> shamt;
                cpuPkg::opShl:  result = a << shamt;
                // Loads, stores, addi and branch targets all add.
                default:        result = a + b;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: datapath/registerFile.sv
`timescale 1ns/1ns
`default_nettype none

module registerFile (
    input  wire           clk,
    input  wire           reset,
    input  cpuPkg::word_t ir,
    input  wire           gra,
    input  wire           grb,
    input  wire           grc,
    input  wire           rIn,
    input  wire           baOut,
    input  cpuPkg::word_t writeData,
    output cpuPkg::word_t readData
);

    cpuPkg::word_t   regs [16];
    cpuPkg::regIdx_t idx;

    // Pick the ra, rb or rc field of the instruction.
    always_comb begin
        if (gra)      idx = ir[26:23];
        else if (grb) idx = ir[22:19];
        else if (grc) idx = ir[18:15];
        else          idx = '0;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 16; i++)
                regs[i] <= '0;
        end else if (rIn) begin
            regs[idx] <= writeData;
        end
    end

    // A base of R0 means an absolute address.
    assign readData = (baOut && idx == '0) ? '0 : regs[idx];

endmodule

`default_nettype wire

// File: datapath/datapath.sv
`timescale 1ns/1ns
`default_nettype none

module datapath (
    input  wire                  clk,
    input  wire                  reset,
    input  cpuPkg::controlWord_t ctrl,
    input  cpuPkg::word_t        memReadData,
    input  cpuPkg::word_t        inport,
    output cpuPkg::word_t        ir,
    output cpuPkg::word_t        memAddr,
    output cpuPkg::word_t        memWriteData,
    output cpuPkg::word_t        outport,
    output logic                 conFf,
    output logic                 outportStrobe
);

    cpuPkg::word_t bus;
    cpuPkg::word_t pc, mar, mdr, y, z;
    cpuPkg::word_t inportReg;
    cpuPkg::word_t regRead, aluResult, cSext;
    logic          condMet;

    assign cSext = {{13{ir[18]}}, ir[18:0]};

    always_comb begin
        bus = '0;
        case (ctrl.busSrc)
            cpuPkg::srcPc:     bus = pc;
            cpuPkg::srcZlo:    bus = z;
            cpuPkg::srcMdr:    bus = mdr;
            cpuPkg::srcReg:    bus = regRead;
            cpuPkg::srcInport: bus = inportReg;
            cpuPkg::srcC:      bus = cSext;
            default:           bus = '0;
        endcase
    end

    // Condition code 2 tests for zero and 3 for nonzero; the others never branch.
    always_comb begin
        case (ir[20:19])
            2'b10:   condMet = (bus == '0);
            2'b11:   condMet = (bus != '0);
            default: condMet = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc            <= '0;
            ir            <= '0;
            conFf         <= 1'b0;
            outport       <= '0;
            outportStrobe <= 1'b0;
        end else begin
            if (ctrl.pcIn) pc <= bus;
            if (ctrl.irIn) ir <= bus;
            if (ctrl.conIn) conFf <= condMet;
            if (ctrl.outportIn) outport <= bus;
            outportStrobe <= ctrl.outportIn;  // One cycle after the outport loads.
        end
    end

    always_ff @(posedge clk) begin
        inportReg <= inport;
        if (ctrl.marIn) mar <= bus;
        if (ctrl.mdrIn) mdr <= ctrl.memRead ? memReadData : bus;
        if (ctrl.yIn) y <= bus;
        if (ctrl.zIn) z <= aluResult;
    end

    assign memAddr      = mar;
    assign memWriteData = mdr;

    registerFile regs (
        .clk(clk), .reset(reset), .ir(ir),
        .gra(ctrl.gra), .grb(ctrl.grb), .grc(ctrl.grc),
        .rIn(ctrl.rIn), .baOut(ctrl.baOut),
        .writeData(bus), .readData(regRead)
    );

    alu aluUnit (
        .op(ctrl.aluOp), .a(y), .b(bus), .incPc(ctrl.incPc), .result(aluResult)
    );

    // IR only loads right after an instruction fetch brought a word into MDR.
    assert property (@(posedge clk) disable iff (reset)
        ctrl.irIn |-> $past(ctrl.mdrIn && ctrl.memRead));

endmodule

`default_nettype wire

// File: control/controlUnit.sv
`timescale 1ns/1ns
`default_nettype none

module controlUnit (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  stop,
    input  cpuPkg::word_t        ir,
    input  wire                  conFf,
    output cpuPkg::controlWord_t ctrl,
    output logic                 run
);

    cpuPkg::tState_t state;
    cpuPkg::opcode_t op;
    logic            halted;   // Set by halt and held until reset.
    logic            memOp;    // ld or st, both use base addressing.
    logic            regOp;    // Three-register ALU instructions.
    logic            immOp;    // addi and andi.
    logic            brOp;

    assign op    = ir[31:27];
    assign memOp = (op == cpuPkg::opLd) || (op == cpuPkg::opSt);
    assign regOp = (op >= cpuPkg::opAdd) && (op <= cpuPkg::opShl);
    assign immOp = (op == cpuPkg::opAddi) || (op == cpuPkg::opAndi);
    assign brOp  = (op == cpuPkg::opBrzr) || (op == cpuPkg::opBrnz);

    assign run = !halted && !(state == cpuPkg::T0 && stop);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= cpuPkg::resetState;
            halted <= 1'b0;
        end else if (!halted) begin
            case (state)
                cpuPkg::resetState: state <= cpuPkg::T0;
                cpuPkg::T0: if (!stop) state <= cpuPkg::T1;  // Stop holds fetch off.
                cpuPkg::T1: state <= cpuPkg::T2;
                cpuPkg::T2: state <= cpuPkg::T3;
                cpuPkg::T3: state <= cpuPkg::T4;
                cpuPkg::T4: state <= cpuPkg::T5;
                cpuPkg::T5: state <= cpuPkg::T6;
                cpuPkg::T6: state <= cpuPkg::T7;
                default:    state <= cpuPkg::T0;
            endcase
            if (state == cpuPkg::T3 && op == cpuPkg::opHalt)
                halted <= 1'b1;
        end
    end

    always_comb begin
        ctrl = '0;
        if (!halted) begin
            case (state)
                cpuPkg::T0: if (!stop) begin
                    ctrl.busSrc = cpuPkg::srcPc;
                    ctrl.marIn  = 1'b1;
                    ctrl.incPc  = 1'b1;
                    ctrl.zIn    = 1'b1;
                end
                cpuPkg::T1: begin
                    ctrl.busSrc  = cpuPkg::srcZlo;
                    ctrl.pcIn    = 1'b1;
                    ctrl.memRead = 1'b1;
                    ctrl.mdrIn   = 1'b1;
                end
                cpuPkg::T2: begin
                    ctrl.busSrc = cpuPkg::srcMdr;
                    ctrl.irIn   = 1'b1;
                end
                cpuPkg::T3: begin
                    if (memOp || op == cpuPkg::opLdi || regOp || immOp) begin
                        ctrl.busSrc = cpuPkg::srcReg;  // Y takes rb.
                        ctrl.grb    = 1'b1;
                        ctrl.baOut  = memOp || op == cpuPkg::opLdi;
                        ctrl.yIn    = 1'b1;
                    end else if (brOp) begin
                        ctrl.busSrc = cpuPkg::srcReg;
                        ctrl.gra    = 1'b1;
                        ctrl.conIn  = 1'b1;
                    end else if (op == cpuPkg::opIn) begin
                        ctrl.busSrc = cpuPkg::srcInport;
                        ctrl.gra    = 1'b1;
                        ctrl.rIn    = 1'b1;
                    end else if (op == cpuPkg::opOut) begin
                        ctrl.busSrc    = cpuPkg::srcReg;
                        ctrl.gra       = 1'b1;
                        ctrl.outportIn = 1'b1;
                    end
                end
                cpuPkg::T4: begin
                    if (memOp || op == cpuPkg::opLdi || immOp) begin
                        ctrl.busSrc = cpuPkg::srcC;
                        ctrl.aluOp  = op;
                        ctrl.zIn    = 1'b1;
                    end else if (regOp) begin
                        ctrl.busSrc = cpuPkg::srcReg;
                        ctrl.grc    = 1'b1;
                        ctrl.aluOp  = op;
                        ctrl.zIn    = 1'b1;
                    end else if (brOp) begin
                        ctrl.busSrc = cpuPkg::srcPc;
                        ctrl.yIn    = 1'b1;
                    end
                end
                cpuPkg::T5: begin
                    if (memOp) begin
                        ctrl.busSrc = cpuPkg::srcZlo;  // Effective address into MAR.
                        ctrl.marIn  = 1'b1;
                    end else if (op == cpuPkg::opLdi || regOp || immOp) begin
                        ctrl.busSrc = cpuPkg::srcZlo;
                        ctrl.gra    = 1'b1;
                        ctrl.rIn    = 1'b1;
                    end else if (brOp) begin
                        ctrl.busSrc = cpuPkg::srcC;
                        ctrl.aluOp  = cpuPkg::opAdd;
                        ctrl.zIn    = 1'b1;
                    end
                end
                cpuPkg::T6: begin
                    if (op == cpuPkg::opLd) begin
                        ctrl.memRead = 1'b1;
                        ctrl.mdrIn   = 1'b1;
                    end else if (op == cpuPkg::opSt) begin
                        ctrl.busSrc = cpuPkg::srcReg;
                        ctrl.gra    = 1'b1;
                        ctrl.mdrIn  = 1'b1;
                    end else if (brOp && conFf) begin
                        ctrl.busSrc = cpuPkg::srcZlo;  // Taken branch target.
                        ctrl.pcIn   = 1'b1;
                    end
                end
                cpuPkg::T7: begin
                    if (op == cpuPkg::opLd) begin
                        ctrl.busSrc = cpuPkg::srcMdr;
                        ctrl.gra    = 1'b1;
                        ctrl.rIn    = 1'b1;
                    end else if (op == cpuPkg::opSt) begin
                        ctrl.memWrite = 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    // Only one driver may own the bus in any step.
    assert property (@(posedge clk) disable iff (reset) $onehot0(ctrl.busSrc));
    assert property (@(posedge clk) disable iff (reset) !(ctrl.memRead && ctrl.memWrite));

endmodule

`default_nettype wire

// File: design/mainMemory.sv
`timescale 1ns/1ns
`default_nettype none

module mainMemory #(
    parameter int memWords = 512
) (
    input  wire           clk,
    input  cpuPkg::word_t addr,
    input  wire           writeEn,
    input  cpuPkg::word_t writeData,
    output cpuPkg::word_t readData,
    input  wire           loadEn,
    input  cpuPkg::word_t loadAddr,
    input  cpuPkg::word_t loadData
);

    localparam int addrBits = $clog2(memWords);

    cpuPkg::word_t mem [memWords];

    assign readData = mem[addr[addrBits-1:0]];

    always_ff @(posedge clk) begin
        if (loadEn)
            mem[loadAddr[addrBits-1:0]] <= loadData;  // Preload wins over the CPU.
        else if (writeEn)
            mem[addr[addrBits-1:0]] <= writeData;
    end

    assert property (@(posedge clk) writeEn |-> addr < memWords);
    assert property (@(posedge clk) loadEn |-> loadAddr < memWords);

endmodule

`default_nettype wire

// File: design/cpuTop.sv
`timescale 1ns/1ns
`default_nettype none

module cpuTop #(
    parameter int memWords = 512
) (
    input  wire           clk,
    input  wire           reset,
    input  wire           stop,
    input  wire           loadEn,
    input  cpuPkg::word_t loadAddr,
    input  cpuPkg::word_t loadData,
    input  cpuPkg::word_t inport,
    output cpuPkg::word_t outport,
    output logic          outportStrobe,
    output logic          run
);

    cpuPkg::controlWord_t ctrl;
    cpuPkg::word_t        ir, memAddr, memWriteData, memReadData;
    logic                 conFf;

    controlUnit control (
        .clk(clk), .reset(reset), .stop(stop),
        .ir(ir), .conFf(conFf), .ctrl(ctrl), .run(run)
    );

    datapath dp (
        .clk(clk), .reset(reset), .ctrl(ctrl),
        .memReadData(memReadData), .inport(inport),
        .ir(ir), .memAddr(memAddr), .memWriteData(memWriteData),
        .outport(outport), .conFf(conFf), .outportStrobe(outportStrobe)
    );

    mainMemory #(.memWords(memWords)) memory (
        .clk(clk), .addr(memAddr), .writeEn(ctrl.memWrite),
        .writeData(memWriteData), .readData(memReadData),
        .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData)
    );

endmodule

`default_nettype wire

// File: tests/cpuTb.sv
`timescale 1ns/1ns
`default_nettype none

module cpuTb;

    localparam int maxTests = 16;

    logic          clk;
    logic          reset;
    logic          stop;
    logic          loadEn;
    cpuPkg::word_t loadAddr;
    cpuPkg::word_t loadData;
    cpuPkg::word_t inport;
    cpuPkg::word_t outport;
    logic          outportStrobe;
    logic          run;

    // Program words and expected values of all tests sit in flat queues.
    string         testName [maxTests];
    cpuPkg::word_t testInport [maxTests];
    int            stopAfter [maxTests];  // Outputs seen before stop is raised, 0 for none.
    int            progFirst [maxTests];
    int            progLast [maxTests];
    int            expFirst [maxTests];
    int            expLast [maxTests];
    cpuPkg::word_t progAddr [$];
    cpuPkg::word_t progWord [$];
    cpuPkg::word_t expVal [$];
    cpuPkg::word_t seen [$];              // Outport values of the running test.
    int            nTests = 0;
    int            totalSteps = 0;
    int            errors = 0;
    int            checks = 0;
    longint        watchdogNs = 0;

    cpuTop #(.memWords(512)) uut (
        .clk(clk), .reset(reset), .stop(stop),
        .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
        .inport(inport), .outport(outport),
        .outportStrobe(outportStrobe), .run(run)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Stops a run that hangs, with a limit taken from the test lengths.
    initial begin
        wait (watchdogNs > 0);
        #(watchdogNs);
        $display("Timeout: the tests did not finish within %0d ns", watchdogNs);
        $display("Checks failed");
        $finish;
    end

    always @(negedge clk) begin
        if (outportStrobe)
            seen.push_back(outport);
    end

    task automatic check(input string what, input cpuPkg::word_t expected,
                         input cpuPkg::word_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERR %s: expected %h, got %h", what, expected, actual);
        end
    endtask

    task automatic afterEdge();
        @(posedge clk);
        #2;
    endtask

    task automatic waitRunLow();
        @(negedge clk);
        while (run)
            @(negedge clk);
    endtask

    task automatic readStim();
        int            fd;
        int            r;
        int            steps;
        int            stopN;
        string         tok;
        string         name;
        string         rest;
        cpuPkg::word_t addr;
        cpuPkg::word_t value;
        addr = '0;
        fd = $fopen("tests/cpuStim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tests/cpuStim.txt");
            errors++;
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok == "#") begin
                    r = $fgets(rest, fd);  // Comment up to the end of the line.
                end else if (tok == "test") begin
                    r = $fscanf(fd, "%s %h %d %d", name, value, stopN, steps);
                    testName[nTests]   = name;
                    testInport[nTests] = value;
                    stopAfter[nTests]  = stopN;
                    progFirst[nTests]  = progWord.size();
                    expFirst[nTests]   = expVal.size();
                    totalSteps += steps;
                end else if (tok == "end") begin
                    progLast[nTests] = progWord.size();
                    expLast[nTests]  = expVal.size();
                    nTests++;
                end else if ($sscanf(tok, "@%h", value) == 1) begin
                    addr = value;
                end else if ($sscanf(tok, "=%h", value) == 1) begin
                    expVal.push_back(value);
                end else if ($sscanf(tok, "%h", value) == 1) begin
                    progAddr.push_back(addr);
                    progWord.push_back(value);
                    addr++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic loadProgram(input int t);
        for (int i = progFirst[t]; i < progLast[t]; i++) begin
            afterEdge();
            loadEn   = 1'b1;
            loadAddr = progAddr[i];
            loadData = progWord[i];
        end
        afterEdge();  // The last word is written at this edge.
        loadEn = 1'b0;
    endtask

    task automatic runTest(input int t);
        int strobesAtHalt;
        int nExp;
        nExp = expLast[t] - expFirst[t];
        afterEdge();
        reset  = 1'b1;
        stop   = 1'b0;
        inport = testInport[t];
        loadProgram(t);
        repeat (5) afterEdge();
        seen.delete();
        reset = 1'b0;
        @(negedge clk);
        check({testName[t], " run after reset"}, 1, run);
        if (stopAfter[t] > 0) begin
            while (seen.size() < stopAfter[t])
                @(posedge clk);
            afterEdge();
            stop = 1'b1;
            waitRunLow();  // The sequencer has parked in T0.
            repeat (10) begin
                @(negedge clk);
                check({testName[t], " strobe while stopped"}, 0, outportStrobe);
            end
            check({testName[t], " run while stopped"}, 0, run);
            afterEdge();
            check({testName[t], " outputs while stopped"}, stopAfter[t], seen.size());
            stop = 1'b0;
            @(negedge clk);
            check({testName[t], " run after stop"}, 1, run);
        end
        waitRunLow();
        @(posedge clk);
        strobesAtHalt = seen.size();
        repeat (16) @(posedge clk);
        check({testName[t], " strobes after halt"}, strobesAtHalt, seen.size());
        check({testName[t], " outport count"}, nExp, seen.size());
        for (int i = 0; i < nExp && i < seen.size(); i++)
            check($sformatf("%s outport %0d", testName[t], i), expVal[expFirst[t] + i],
                  seen[i]);
        @(negedge clk);
        check({testName[t], " run after halt"}, 0, run);
    endtask

    initial begin
        reset    = 1'b1;
        stop     = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        inport   = '0;
        readStim();
        // Eight cycles per instruction plus setup per test, with a margin of two.
        watchdogNs = longint'(totalSteps * 8 + nTests * 40 + progWord.size()) * 20 * 2;
        for (int t = 0; t < nTests; t++)
            runTest(t);
        $display("%0d tests, %0d checks, %0d errors", nTests, checks, errors);
        if (errors == 0 && nTests > 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/cpuStim.txt
# Record: test <name> <inport hex> <stop after n outputs, 0 for none> <instructions run>
# Then @addr sets the load address, hex words load in order, =value is an expected output.
test aluReg 00000000 0 12
@000 08812345 0907ffff 19890000 71800000 22090000 72000000 2a890000 72800000
0b00f0f0 338b0000 73800000 d8000000
=00012344 =00012346 =00012345 =0001f3f5 end
test immShift 00000000 0 11
@000 088000f3 490ffff0 71000000 518ffffc 71800000 0a000024 428a0000 72800000
3b2a0000 73000000 d8000000
=000000e3 =000000f0 =00000f30 =000000f3 end
test memory 00000000 0 11
@000 08800100 0902a5a5 08000055 11080020 01800120 71800000 70000000 10800130
02080030 72000000 d8000000
=0002a5a5 =00000055 =00000100 end
test branch 00000000 0 19
@000 08800000 09000005 58900001 71000000 60980001 71000000 59100001 70800000
61180002 71000000 71000000 09800003 71800000 499fffff 619ffffd d8000000
=00000005 =00000000 =00000003 =00000002 =00000001 end
test inport cafe1234 0 3
@000 6a800000 72800000 d8000000
=cafe1234 end
test haltStop 00000000 1 7
@000 08800001 70800000 48880001 70800000 48880001 70800000 d8000000
=00000001 =00000002 =00000003 end

// File: sim.f
common/cpuPkg.sv
datapath/alu.sv
datapath/registerFile.sv
datapath/datapath.sv
control/controlUnit.sv
design/mainMemory.sv
design/cpuTop.sv
tests/cpuTb.sv

// File: Bender.yml
package:
  name: accuCpu

sources:
  - common/cpuPkg.sv
  - datapath/alu.sv
  - datapath/registerFile.sv
  - datapath/datapath.sv
  - control/controlUnit.sv
  - design/mainMemory.sv
  - design/cpuTop.sv
  - target: simulation
    files:
      - tests/cpuTb.sv
